/* hw/trs80_cfg.svh */
`ifndef TRS80_CFG_SVH
`define TRS80_CFG_SVH

// bus widths
`define TRS_DATA_W 8
`define TRS_ADDR_W 16

// i/o port group bases, decoded on addr[7:2]
`define TRS_PORT_HIRES   8'h80 // 80-83 hi-res x, y, data, options
`define TRS_PORT_OPREG   8'h84 // 84-87 operation register
`define TRS_PORT_INTMASK 8'he0 // e0-e3 int mask / int status
`define TRS_PORT_NMIMASK 8'he4 // e4-e7 nmi status
`define TRS_PORT_MOD     8'hec // ec-ef mod register, rtc clear on read
`define TRS_PORT_DISK    8'hf0 // f0-f3 disk controller
`define TRS_PORT_CASS    8'hfc // fc-ff cassette

// orchestra-90 channels, full 8-bit decode
`define TRS_PORT_ORCH_L 8'h75
`define TRS_PORT_ORCH_R 8'h79

// no drive fitted, fdc answers seek error on track 0
`define TRS_FDC_STAT  8'h34
`define TRS_FDC_TRACK 8'h00

// what the cpu sees on an undriven read
`define TRS_IDLE_BUS 8'hff

// memory map boundaries, low end of each region
`define TRS_MAP_KBD_LO 16'h3800 // mode 0/1 keyboard
`define TRS_MAP_DSP_LO 16'h3c00 // mode 0/1 display
`define TRS_MAP_RAM_LO 16'h4000 // mode 0 ram above rom
`define TRS_MAP_KBD_HI 16'hf400 // mode 2 keyboard
`define TRS_MAP_DSP_HI 16'hf800 // mode 2 display, runs to ffff

`endif

/* hw/trs80_pkg.sv */
package trs80_pkg;

   // z80 side
   typedef logic [15:0] addr_t; // cpu address
   typedef logic [7:0]  data_t; // cpu data byte

   // port 84 bits 1..0
   typedef logic [1:0] map_mode_t;

   // ram banking
   typedef logic [1:0]  ram_bank_t; // 4 banks of 32k
   typedef logic [16:0] ram_addr_t; // {bank, a14..a0}

   // display ram, 2k in two 1k pages
   typedef logic [10:0] dsp_addr_t;

   // hi-res board
   typedef logic [7:0]  hires_coord_t; // x or y register
   typedef logic [14:0] hires_addr_t;  // {x[6:0], y}

endpackage

/* hw/z80_bus_if.sv */
interface z80_bus_if
   import trs80_pkg::*;
   ();

   logic  mreq;  // memory request, active high
   logic  iorq;  // io request, active high
   logic  rd;    // read strobe
   logic  wr;    // write strobe
   addr_t addr;
   data_t wdata; // cpu write data

   // cpu side drives the cycle
   modport cpu (
      output mreq, iorq, rd, wr, addr, wdata
   );

   // internal blocks only look
   modport periph (
      input mreq, iorq, rd, wr, addr, wdata
   );

endinterface

/* hw/mem_map_decode.sv */
`include "trs80_cfg.svh"

module mem_map_decode
   import trs80_pkg::*;
(
   z80_bus_if.periph bus,
   input  map_mode_t  map_mode,
   input  logic       fxupmem,
   input  logic [1:0] mbit,
   input  logic       dsp_page,
   output logic       rom_sel,
   output logic       ram_sel,
   output logic       dsp_sel,
   output logic       kbd_sel,
   output ram_addr_t  ram_addr,
   output dsp_addr_t  dsp_addr
);

   ram_bank_t bank;
   logic      a15;
   logic      lo_kbd; // 3800-3bff
   logic      lo_dsp; // 3c00-3fff

   assign a15 = bus.addr[15];

   assign lo_kbd = (bus.addr >= `TRS_MAP_KBD_LO) && (bus.addr < `TRS_MAP_DSP_LO);
   assign lo_dsp = (bus.addr >= `TRS_MAP_DSP_LO) && (bus.addr < `TRS_MAP_RAM_LO);

   // region selects
   always_comb
   begin
      rom_sel = 1'b0;
      ram_sel = 1'b0;
      dsp_sel = 1'b0;
      kbd_sel = 1'b0;
      if (bus.mreq)
      begin
         case (map_mode)
            2'd0:
            begin
               rom_sel = bus.addr < `TRS_MAP_KBD_LO; // 14k rom
               kbd_sel = lo_kbd;
               dsp_sel = lo_dsp;
               ram_sel = bus.addr >= `TRS_MAP_RAM_LO; // 48k ram
            end
            2'd1:
            begin
               // rom swapped out, ram fills the hole
               kbd_sel = lo_kbd;
               dsp_sel = lo_dsp;
               ram_sel = !(lo_kbd || lo_dsp);
            end
            2'd2:
            begin
               // keyboard and video moved to top of map
               kbd_sel = (bus.addr >= `TRS_MAP_KBD_HI) && (bus.addr < `TRS_MAP_DSP_HI);
               dsp_sel = bus.addr >= `TRS_MAP_DSP_HI;
               ram_sel = bus.addr < `TRS_MAP_KBD_HI;
            end
            default:
               ram_sel = 1'b1; // all 64k ram
         endcase
      end
   end

   // bank from fxupmem, mbit and a15
   always_comb
   begin
      if (!mbit[1])
         bank = {1'b0, a15}; // banking off, plain 64k
      else if (!fxupmem)
         bank = a15 ? {1'b1, mbit[0]} : 2'd0; // upper 32k swapped
      else
         bank = a15 ? 2'd1 : {1'b1, mbit[0]}; // lower 32k swapped
   end

   assign ram_addr = {bank, bus.addr[14:0]};

   // page bit from port 84 unless in the 2k display modes
   assign dsp_addr = {(map_mode[1] ? bus.addr[10] : dsp_page), bus.addr[9:0]};

endmodule

/* hw/io_port_block.sv */
`include "trs80_cfg.svh"

module io_port_block
   import trs80_pkg::*;
(
   input  logic       z80_clk,
   input  logic       z80_rst_n,
   z80_bus_if.periph  bus,
   input  logic       hires_rd,
   input  data_t      hires_rdata,
   input  logic       cass_in,
   input  logic       rtc_tick,
   output map_mode_t  map_mode,
   output logic       dsp_page,
   output logic       fxupmem,
   output logic [1:0] mbit,
   output logic       int_n,
   output logic       cpu_fast,
   output logic       col_double,
   output logic [1:0] cass_out,
   output data_t      io_rdata
);

   localparam data_t OPREG_BASE = `TRS_PORT_OPREG;
   localparam data_t INT_BASE   = `TRS_PORT_INTMASK;
   localparam data_t NMI_BASE   = `TRS_PORT_NMIMASK;
   localparam data_t MOD_BASE   = `TRS_PORT_MOD;
   localparam data_t DISK_BASE  = `TRS_PORT_DISK;
   localparam data_t CASS_BASE  = `TRS_PORT_CASS;
   localparam data_t NMI_STAT   = 8'hff; // no nmi sources left, all inactive

   logic       opreg_sel, int_sel, nmi_sel, mod_sel, disk_sel, cass_sel;
   logic       io_rd;
   data_t      opreg;    // 84
   data_t      int_mask; // e0, 1 enables
   data_t      mod_reg;  // ec
   logic [1:0] cass_reg; // fc, only the two output bits
   logic       rtc_q;    // tick sampled
   logic       rtc_int;
   data_t      int_stat; // 0 = active

   assign opreg_sel = bus.iorq && (bus.addr[7:2] == OPREG_BASE[7:2]);
   assign int_sel   = bus.iorq && (bus.addr[7:2] == INT_BASE[7:2]);
   assign nmi_sel   = bus.iorq && (bus.addr[7:2] == NMI_BASE[7:2]);
   assign mod_sel   = bus.iorq && (bus.addr[7:2] == MOD_BASE[7:2]);
   assign disk_sel  = bus.iorq && (bus.addr[7:2] == DISK_BASE[7:2]);
   assign cass_sel  = bus.iorq && (bus.addr[7:2] == CASS_BASE[7:2]);
   assign io_rd     = bus.iorq && bus.rd;

   always_ff @(posedge z80_clk or negedge z80_rst_n)
   begin
      if (!z80_rst_n)
      begin
         opreg    <= '0;
         int_mask <= '0;
         mod_reg  <= '0;
         cass_reg <= '0;
         rtc_q    <= 1'b0;
         rtc_int  <= 1'b0;
      end
      else
      begin
         if (opreg_sel && bus.wr)
            opreg <= bus.wdata;
         if (int_sel && bus.wr)
            int_mask <= bus.wdata;
         if (mod_sel && bus.wr)
            mod_reg <= bus.wdata;
         if (cass_sel && bus.wr)
            cass_reg <= bus.wdata[1:0];
         rtc_q <= rtc_tick;
         if (mod_sel && io_rd) // reading ec acks the rtc
            rtc_int <= 1'b0;
         else if (rtc_q)
            rtc_int <= 1'b1;
      end
   end

   // port 84 fields
   assign map_mode = opreg[1:0];
   assign mbit     = opreg[5:4];
   assign fxupmem  = opreg[6];
   assign dsp_page = opreg[7];

   assign cpu_fast   = mod_reg[6];
   assign col_double = mod_reg[2]; // 32/40 column mode
   assign cass_out   = {~cass_reg[1], cass_reg[0]};

   assign int_stat = ~{5'b00000, rtc_int, 2'b00}; // rtc is bit 2
   assign int_n    = ~|(~int_stat & int_mask);

   // read mux, idle bus unless a port answers
   always_comb
   begin
      io_rdata = `TRS_IDLE_BUS;
      if (io_rd)
      begin
         if (hires_rd)
            io_rdata = hires_rdata; // port 82
         else if (int_sel)
            io_rdata = int_stat;
         else if (nmi_sel)
            io_rdata = NMI_STAT;
         else if (disk_sel)
         begin
            case (bus.addr[1:0])
               2'b00:   io_rdata = `TRS_FDC_STAT;
               2'b01:   io_rdata = `TRS_FDC_TRACK;
               default: io_rdata = `TRS_IDLE_BUS;
            endcase
         end
         else if (cass_sel)
            io_rdata = {cass_in, mod_reg[6:1], 1'b0};
      end
   end

endmodule

/* hw/hires_addr_gen.sv */
`include "trs80_cfg.svh"

module hires_addr_gen
   import trs80_pkg::*;
(
   input  logic       z80_clk,
   input  logic       z80_rst_n,
   z80_bus_if.periph  bus,
   output hires_addr_t hires_addr,
   output logic        hires_rd,
   output logic        hires_wr,
   output logic        hires_on
);

   localparam data_t HIRES_BASE = `TRS_PORT_HIRES;

   hires_coord_t x_reg;
   hires_coord_t y_reg;
   data_t        opts;     // port 83
   logic         grp_sel;  // 80-83
   logic         data_sel; // 82
   logic         acc_rd;   // access in progress at 82
   logic         acc_wr;
   logic         step_x, step_y;

   assign grp_sel  = bus.iorq && (bus.addr[7:2] == HIRES_BASE[7:2]);
   assign data_sel = grp_sel && (bus.addr[1:0] == 2'b10);

   // option bits are active-low clock enables
   assign step_x = (acc_rd && !opts[4]) || (acc_wr && !opts[6]);
   assign step_y = (acc_rd && !opts[5]) || (acc_wr && !opts[7]);

   always_ff @(posedge z80_clk or negedge z80_rst_n)
   begin
      if (!z80_rst_n)
      begin
         x_reg  <= '0;
         y_reg  <= '0;
         opts   <= '0;
         acc_rd <= 1'b0;
         acc_wr <= 1'b0;
      end
      else
      begin
         if (data_sel)
         begin
            if (bus.rd)
               acc_rd <= 1'b1;
            if (bus.wr)
               acc_wr <= 1'b1;
         end
         else
         begin
            // post-modify once the access is over
            if (step_x)
               x_reg <= x_reg + (opts[2] ? 8'hff : 8'h01);
            if (step_y)
               y_reg <= y_reg + (opts[3] ? 8'hff : 8'h01);
            acc_rd <= 1'b0;
            acc_wr <= 1'b0;
         end
         // direct loads win over a pending step
         if (grp_sel && bus.wr && (bus.addr[1:0] == 2'b00))
            x_reg <= bus.wdata;
         if (grp_sel && bus.wr && (bus.addr[1:0] == 2'b01))
            y_reg <= bus.wdata;
         if (grp_sel && bus.wr && (bus.addr[1:0] == 2'b11))
            opts <= bus.wdata;
      end
   end

   assign hires_addr = {x_reg[6:0], y_reg};
   assign hires_rd   = data_sel && bus.rd;
   assign hires_wr   = data_sel && bus.wr;
   assign hires_on   = opts[0]; // graphics enable

endmodule

/* hw/orch90_dac.sv */
module orch90_dac
   import trs80_pkg::*;
#(
   parameter data_t PORT_ADDR = 8'h75
)
(
   input  logic      z80_clk,
   input  logic      z80_rst_n,
   z80_bus_if.periph bus,
   output logic      pdm_out
);

   data_t      sample;
   data_t      acc;
   logic [8:0] sum; // carry in bit 8

   // samples are signed, flip msb for offset binary
   assign sum = {1'b0, acc} + {1'b0, sample ^ 8'h80};

   always_ff @(posedge z80_clk or negedge z80_rst_n)
   begin
      if (!z80_rst_n)
      begin
         sample  <= '0;
         acc     <= '0;
         pdm_out <= 1'b0;
      end
      else
      begin
         if (bus.iorq && bus.wr && (bus.addr[7:0] == PORT_ADDR))
            sample <= bus.wdata;
         acc     <= sum[7:0];
         pdm_out <= sum[8]; // ones density = sample'/256
      end
   end

endmodule

/* hw/trs80_glue_top.sv */
`include "trs80_cfg.svh"

module trs80_glue_top
   import trs80_pkg::*;
(
   input  logic                   z80_clk,
   input  logic                   z80_rst_n,
   input  logic                   mreq,
   input  logic                   iorq,
   input  logic                   rd,
   input  logic                   wr,
   input  logic [`TRS_ADDR_W-1:0] addr,
   input  logic [`TRS_DATA_W-1:0] wdata,
   output logic [`TRS_DATA_W-1:0] io_rdata,
   output logic                   rom_sel,
   output logic                   ram_sel,
   output logic                   dsp_sel,
   output logic                   kbd_sel,
   output ram_addr_t              ram_addr,
   output dsp_addr_t              dsp_addr,
   output hires_addr_t            hires_addr,
   output logic                   hires_rd,
   output logic                   hires_wr,
   input  logic [`TRS_DATA_W-1:0] hires_rdata,
   output logic                   int_n,
   output logic [1:0]             cass_out,
   input  logic                   cass_in,
   output logic                   cpu_fast,
   output logic                   col_double,
   output logic                   hires_on,
   input  logic                   rtc_tick,
   output logic                   orch_l_out,
   output logic                   orch_r_out
);

   map_mode_t  map_mode;
   logic       dsp_page;
   logic       fxupmem;
   logic [1:0] mbit;

   z80_bus_if bus ();

   // cpu pins onto the internal bus
   assign bus.mreq  = mreq;
   assign bus.iorq  = iorq;
   assign bus.rd    = rd;
   assign bus.wr    = wr;
   assign bus.addr  = addr;
   assign bus.wdata = wdata;

   mem_map_decode u_map (
      .bus(bus), .map_mode(map_mode), .fxupmem(fxupmem), .mbit(mbit),
      .dsp_page(dsp_page), .rom_sel(rom_sel), .ram_sel(ram_sel),
      .dsp_sel(dsp_sel), .kbd_sel(kbd_sel), .ram_addr(ram_addr), .dsp_addr(dsp_addr)
   );

   io_port_block u_io (
      .z80_clk(z80_clk), .z80_rst_n(z80_rst_n), .bus(bus),
      .hires_rd(hires_rd), .hires_rdata(hires_rdata), .cass_in(cass_in),
      .rtc_tick(rtc_tick), .map_mode(map_mode), .dsp_page(dsp_page),
      .fxupmem(fxupmem), .mbit(mbit), .int_n(int_n), .cpu_fast(cpu_fast),
      .col_double(col_double), .cass_out(cass_out), .io_rdata(io_rdata)
   );

   hires_addr_gen u_hires (
      .z80_clk(z80_clk), .z80_rst_n(z80_rst_n), .bus(bus),
      .hires_addr(hires_addr), .hires_rd(hires_rd), .hires_wr(hires_wr),
      .hires_on(hires_on)
   );

   orch90_dac #(.PORT_ADDR(`TRS_PORT_ORCH_L)) u_orch_l ( // left channel
      .z80_clk(z80_clk), .z80_rst_n(z80_rst_n), .bus(bus), .pdm_out(orch_l_out)
   );

   orch90_dac #(.PORT_ADDR(`TRS_PORT_ORCH_R)) u_orch_r ( // right channel
      .z80_clk(z80_clk), .z80_rst_n(z80_rst_n), .bus(bus), .pdm_out(orch_r_out)
   );

endmodule

/* verification/tb_trs80_glue.sv */
`include "trs80_cfg.svh"

module tb_trs80_glue
   import trs80_pkg::*;
   ();

   localparam int CLK_PERIOD   = 4;
   localparam int RESET_CYCLES = 5;
   localparam int TEST_CYCLES  = 1000; // ports 22, rtc 19, map 284, bank 96, hires 44, orch 522
   localparam int MARGIN       = 250;

   logic        z80_clk;
   logic        z80_rst_n;
   logic        mreq;
   logic        iorq;
   logic        rd;
   logic        wr;
   addr_t       addr;
   data_t       wdata;
   data_t       io_rdata;
   logic        rom_sel;
   logic        ram_sel;
   logic        dsp_sel;
   logic        kbd_sel;
   ram_addr_t   ram_addr;
   dsp_addr_t   dsp_addr;
   hires_addr_t hires_addr;
   logic        hires_rd;
   logic        hires_wr;
   data_t       hires_rdata;
   logic        int_n;
   logic [1:0]  cass_out;
   logic        cass_in;
   logic        cpu_fast;
   logic        col_double;
   logic        hires_on;
   logic        rtc_tick;
   logic        orch_l_out;
   logic        orch_r_out;
   integer      seed;

   trs80_glue_top uut (
      .z80_clk(z80_clk), .z80_rst_n(z80_rst_n), .mreq(mreq), .iorq(iorq), .rd(rd),
      .wr(wr), .addr(addr), .wdata(wdata), .io_rdata(io_rdata), .rom_sel(rom_sel),
      .ram_sel(ram_sel), .dsp_sel(dsp_sel), .kbd_sel(kbd_sel), .ram_addr(ram_addr),
      .dsp_addr(dsp_addr), .hires_addr(hires_addr), .hires_rd(hires_rd),
      .hires_wr(hires_wr), .hires_rdata(hires_rdata), .int_n(int_n), .cass_out(cass_out),
      .cass_in(cass_in), .cpu_fast(cpu_fast), .col_double(col_double),
      .hires_on(hires_on), .rtc_tick(rtc_tick), .orch_l_out(orch_l_out),
      .orch_r_out(orch_r_out)
   );

   initial
   begin
      z80_clk = 1'b0;
      forever #(CLK_PERIOD / 2) z80_clk = ~z80_clk;
   end

   // hang guard
   initial
   begin
      #((RESET_CYCLES + TEST_CYCLES + MARGIN) * CLK_PERIOD);
      $display("timeout: the tests did not finish within the cycle budget");
      $display("Test failures found");
      $fatal(1, "watchdog expired");
   end

   task automatic stop_on_error(input string msg);
      $display("CHECK FAILED at time %0t: %s", $time, msg);
      $display("Test failures found");
      $fatal(1, "stopping at first error");
   endtask

   task automatic expect_byte(input data_t got, input data_t exp, input string what);
      assert (got == exp)
      else stop_on_error($sformatf("%s read %02h, expected %02h", what, got, exp));
   endtask

   task automatic idle_bus();
      mreq  = 1'b0;
      iorq  = 1'b0;
      rd    = 1'b0;
      wr    = 1'b0;
      addr  = '0;
      wdata = '0;
   endtask

   // one-cycle out, register visible on return
   task automatic io_write(input data_t port, input data_t val);
      @(negedge z80_clk);
      addr  = {8'h00, port};
      wdata = val;
      iorq  = 1'b1;
      wr    = 1'b1;
      @(negedge z80_clk);
      idle_bus();
   endtask

   task automatic io_read(input data_t port, output data_t val);
      @(negedge z80_clk);
      addr = {8'h00, port};
      iorq = 1'b1;
      rd   = 1'b1;
      #1;
      val = io_rdata; // combinational answer
      @(negedge z80_clk);
      idle_bus();
   endtask

   // {rom, ram, dsp, kbd} per map mode
   function automatic logic [3:0] expected_selects(input logic [1:0] mode, input addr_t a);
      logic rom;
      logic ram;
      logic dsp;
      logic kbd;
      rom = 1'b0;
      ram = 1'b0;
      dsp = 1'b0;
      kbd = 1'b0;
      case (mode)
         2'd0:
         begin
            rom = a < 16'h3800;
            kbd = (a >= 16'h3800) && (a < 16'h3c00);
            dsp = (a >= 16'h3c00) && (a < 16'h4000);
            ram = a >= 16'h4000;
         end
         2'd1:
         begin
            kbd = (a >= 16'h3800) && (a < 16'h3c00);
            dsp = (a >= 16'h3c00) && (a < 16'h4000);
            ram = !(kbd || dsp);
         end
         2'd2:
         begin
            kbd = (a >= 16'hf400) && (a < 16'hf800);
            dsp = a >= 16'hf800;
            ram = a < 16'hf400;
         end
         default:
            ram = 1'b1;
      endcase
      expected_selects = {rom, ram, dsp, kbd};
   endfunction

   // region boundaries of all modes
   function automatic addr_t edge_addr(input logic [3:0] idx);
      case (idx)
         4'd0:    edge_addr = 16'h37ff;
         4'd1:    edge_addr = 16'h3800;
         4'd2:    edge_addr = 16'h3bff;
         4'd3:    edge_addr = 16'h3c00;
         4'd4:    edge_addr = 16'h3fff;
         4'd5:    edge_addr = 16'h4000;
         4'd6:    edge_addr = 16'hf3ff;
         4'd7:    edge_addr = 16'hf400;
         4'd8:    edge_addr = 16'hf7ff;
         default: edge_addr = 16'hf800;
      endcase
   endfunction

   function automatic ram_bank_t expected_bank(input logic fx, input logic [1:0] mb,
                                               input logic a15);
      if (!mb[1])
         expected_bank = a15 ? 2'd1 : 2'd0; // plain 64k
      else
      begin
         case ({fx, mb[0], a15})
            3'b000:  expected_bank = 2'd0;
            3'b001:  expected_bank = 2'd2;
            3'b010:  expected_bank = 2'd0;
            3'b011:  expected_bank = 2'd3;
            3'b100:  expected_bank = 2'd2;
            3'b101:  expected_bank = 2'd1;
            3'b110:  expected_bank = 2'd3;
            default: expected_bank = 2'd1;
         endcase
      end
   endfunction

   // x/y step patterns: inc both, dec both, x frozen, y frozen with x dec
   function automatic data_t hires_option(input logic [1:0] k);
      case (k)
         2'd0:    hires_option = 8'h01;
         2'd1:    hires_option = 8'h0d;
         2'd2:    hires_option = 8'h51;
         default: hires_option = 8'ha4;
      endcase
   endfunction

   task automatic ports_and_config();
      data_t v;
      data_t w;
      // straight out of reset
      assert (int_n && cass_out == 2'b10 && !cpu_fast && !col_double && !hires_on)
      else stop_on_error("outputs do not hold their reset values");
      @(negedge z80_clk);
      mreq = 1'b1;
      addr = 16'h0000;
      #1;
      assert (rom_sel) else stop_on_error("map mode after reset is not 0");
      @(negedge z80_clk);
      idle_bus();
      io_read(8'he4, v);
      expect_byte(v, 8'hff, "port e4");
      io_read(8'hf0, v);
      expect_byte(v, 8'h34, "port f0");
      io_read(8'hf1, v);
      expect_byte(v, 8'h00, "port f1");
      w = data_t'($random(seed));
      io_write(8'hec, w);
      assert (cpu_fast == w[6] && col_double == w[2])
      else stop_on_error($sformatf("cpu_fast/col_double wrong after ec=%02h", w));
      cass_in = 1'b1;
      io_read(8'hfc, v);
      expect_byte(v, {1'b1, w[6:1], 1'b0}, "port fc, cass_in high");
      cass_in = 1'b0;
      io_read(8'hfe, v); // any port of the fc group
      expect_byte(v, {1'b0, w[6:1], 1'b0}, "port fe, cass_in low");
      io_write(8'hfc, 8'h03);
      assert (cass_out == 2'b01) else stop_on_error("cass_out wrong after fc=03");
      io_write(8'hfc, 8'h00);
      assert (cass_out == 2'b10) else stop_on_error("cass_out wrong after fc=00");
      io_read(8'h50, v);
      expect_byte(v, 8'hff, "unused port 50");
      io_write(8'hec, 8'h00);
   endtask

   task automatic rtc_interrupt();
      data_t v;
      io_write(8'he0, 8'h04); // unmask rtc
      assert (int_n) else stop_on_error("int_n low with no rtc tick");
      io_read(8'he0, v);
      expect_byte(v, 8'hff, "status e0, idle");
      @(negedge z80_clk);
      rtc_tick = 1'b1;
      @(negedge z80_clk);
      rtc_tick = 1'b0;
      #1;
      assert (int_n) else stop_on_error("rtc latch set on the sampling edge");
      @(negedge z80_clk);
      #1;
      assert (!int_n) else stop_on_error("int_n did not fall after the rtc tick");
      io_write(8'he0, 8'hfb); // every mask bit but the rtc
      assert (int_n) else stop_on_error("masked rtc still pulls int_n");
      io_read(8'he0, v);
      expect_byte(v, 8'hfb, "status e0, rtc pending");
      io_write(8'he0, 8'h04);
      assert (!int_n) else stop_on_error("int_n high with rtc pending and unmasked");
      io_read(8'hec, v); // ack
      assert (int_n) else stop_on_error("int_n still low after ec read");
      io_read(8'he0, v);
      expect_byte(v, 8'hff, "status e0, after ack");
      io_write(8'he0, 8'h00);
   endtask

   task automatic memory_map();
      addr_t       a;
      logic [31:0] r;
      int          m;
      int          i;
      for (m = 0; m < 4; m++)
      begin
         io_write(8'h84, data_t'(m));
         for (i = 0; i < 34; i++)
         begin
            r = $random(seed);
            if (i < 10)
               a = edge_addr(i[3:0]);
            else if (i % 3 == 0)
               a = r[15:0];
            else if (i % 3 == 1)
               a = {4'b0011, r[11:0]}; // low keyboard/display area
            else
               a = {4'b1111, r[11:0]}; // high keyboard/display area
            @(negedge z80_clk);
            mreq = 1'b1;
            rd   = 1'b1;
            addr = a;
            #1;
            assert ({rom_sel, ram_sel, dsp_sel, kbd_sel} == expected_selects(m[1:0], a))
            else stop_on_error($sformatf("mode %0d addr %04h selects %b", m, a,
                                         {rom_sel, ram_sel, dsp_sel, kbd_sel}));
            @(negedge z80_clk);
            mreq = 1'b0;
            #1;
            assert (!(rom_sel || ram_sel || dsp_sel || kbd_sel))
            else stop_on_error($sformatf("select active without mreq at %04h", a));
         end
         @(negedge z80_clk);
         idle_bus();
      end
   endtask

   task automatic bank_and_page();
      addr_t       a;
      logic [31:0] r;
      int          fx;
      int          mb;
      int          hi;
      int          m;
      int          page;
      for (fx = 0; fx < 2; fx++)
      begin
         for (mb = 0; mb < 4; mb++)
         begin
            io_write(8'h84, {1'b0, fx[0], mb[1:0], 4'b0000});
            for (hi = 0; hi < 2; hi++)
            begin
               r = $random(seed);
               a = {hi[0], r[14:0]};
               @(negedge z80_clk);
               mreq = 1'b1;
               addr = a;
               #1;
               assert (ram_addr == {expected_bank(fx[0], mb[1:0], hi[0]), a[14:0]})
               else stop_on_error($sformatf("fx %0d mbit %0d addr %04h ram_addr %05h",
                                            fx, mb, a, ram_addr));
            end
            @(negedge z80_clk);
            idle_bus();
         end
      end
      for (m = 0; m < 4; m++)
      begin
         for (page = 0; page < 2; page++)
         begin
            io_write(8'h84, {page[0], 5'b00000, m[1:0]});
            repeat (4)
            begin
               r = $random(seed);
               a = r[15:0];
               @(negedge z80_clk);
               mreq = 1'b1;
               addr = a;
               #1;
               // 2k display in modes 2/3, paged 1k below
               assert (dsp_addr == {((m >= 2) ? a[10] : page[0]), a[9:0]})
               else stop_on_error($sformatf("mode %0d page %0d addr %04h dsp_addr %03h",
                                            m, page, a, dsp_addr));
            end
            @(negedge z80_clk);
            idle_bus();
         end
      end
   endtask

   task automatic hires_stepping();
      hires_coord_t x;
      hires_coord_t y;
      data_t        opt;
      data_t        d;
      logic         rd_acc;
      int           k;
      int           j;
      x = hires_coord_t'($random(seed));
      y = hires_coord_t'($random(seed));
      io_write(8'h80, x);
      io_write(8'h81, y);
      for (k = 0; k < 4; k++)
      begin
         opt = hires_option(k[1:0]);
         io_write(8'h83, opt);
         assert (hires_on == opt[0]) else stop_on_error("hires_on not option bit 0");
         for (j = 0; j < 2; j++)
         begin
            rd_acc = (j == 1); // write first, then read
            d      = data_t'($random(seed));
            @(negedge z80_clk);
            addr        = 16'h0082;
            iorq        = 1'b1;
            rd          = rd_acc;
            wr          = !rd_acc;
            wdata       = d;
            hires_rdata = d;
            repeat (2) // two cycles at 82, no step yet
            begin
               #1;
               assert (hires_addr == {x[6:0], y} && hires_rd == rd_acc && hires_wr == !rd_acc)
               else stop_on_error($sformatf("opt %02h access addr %04h, expected %04h",
                                            opt, hires_addr, {x[6:0], y}));
               if (rd_acc)
                  expect_byte(io_rdata, d, "port 82");
               @(negedge z80_clk);
            end
            idle_bus();
            // clock enables are active low
            if (!(rd_acc ? opt[4] : opt[6]))
               x = opt[2] ? x - 8'd1 : x + 8'd1;
            if (!(rd_acc ? opt[5] : opt[7]))
               y = opt[3] ? y - 8'd1 : y + 8'd1;
            @(negedge z80_clk);
            #1;
            assert (hires_addr == {x[6:0], y})
            else stop_on_error($sformatf("opt %02h after access addr %04h, expected %04h",
                                         opt, hires_addr, {x[6:0], y}));
         end
      end
   endtask

   task automatic orchestra_pdm();
      data_t s;
      data_t t;
      int    cnt_l;
      int    cnt_r;
      int    n;
      for (n = 0; n < 2; n++)
      begin
         s = (n == 0) ? data_t'($random(seed)) : 8'h7f; // full scale
         t = (n == 0) ? data_t'($random(seed)) : 8'h80; // bottom
         io_write(8'h75, s);
         io_write(8'h79, t);
         @(negedge z80_clk); // first carry from the new right sample
         cnt_l = 0;
         cnt_r = 0;
         repeat (256)
         begin
            if (orch_l_out)
               cnt_l++;
            if (orch_r_out)
               cnt_r++;
            @(negedge z80_clk);
         end
         assert (cnt_l == int'(s ^ 8'h80))
         else stop_on_error($sformatf("left sample %02h gave %0d ones", s, cnt_l));
         assert (cnt_r == int'(t ^ 8'h80))
         else stop_on_error($sformatf("right sample %02h gave %0d ones", t, cnt_r));
      end
   endtask

   initial
   begin
      seed        = 32'haadf_9cf9;
      z80_rst_n   = 1'b0;
      hires_rdata = '0;
      cass_in     = 1'b0;
      rtc_tick    = 1'b0;
      idle_bus();
      repeat (RESET_CYCLES) @(posedge z80_clk);
      @(negedge z80_clk);
      z80_rst_n = 1'b1;
      #1;
      ports_and_config(); // needs the reset state, so first
      rtc_interrupt();
      memory_map();
      bank_and_page();
      hires_stepping();
      orchestra_pdm();
      $display("All tests passed!");
      $finish;
   end

endmodule

/* src.f */
+incdir+hw
hw/trs80_pkg.sv
hw/z80_bus_if.sv
hw/mem_map_decode.sv
hw/io_port_block.sv
hw/hires_addr_gen.sv
hw/orch90_dac.sv
hw/trs80_glue_top.sv
verification/tb_trs80_glue.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the testbench with verilator, run it, and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_trs80_glue -f src.f -o tb_sim || exit 1

sim_out="$(./obj_dir/tb_sim 2>&1)"
echo "$sim_out"

echo "$sim_out" | grep -qF "All tests passed!" && echo "simulation PASSED" \
   || { echo "simulation FAILED"; exit 1; }
